// File: bench/axi_ser_assert.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ser_assert (
  input wire logic           clk_i,
  input wire logic           rst_n_i,
  input wire axi_pkg::req_t  slv_req_i,
  input wire axi_pkg::resp_t slv_resp_i,
  input wire axi_pkg::req_t  mst_req_i,
  input wire axi_pkg::resp_t mst_resp_i,
  input wire logic           wr_empty_i,
  input wire logic           rd_empty_i
);

  // Downstream requests always run on ID zero
  aw_id_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_req_i.aw_valid |-> (mst_req_i.aw.id == '0))
    else $error("Downstream AW carries a nonzero ID");

  ar_id_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_req_i.ar_valid |-> (mst_req_i.ar.id == '0))
    else $error("Downstream AR carries a nonzero ID");

  // The memory only answers transactions whose ID has been recorded
  b_has_id: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_resp_i.b_valid |-> !wr_empty_i)
    else $error("B valid raised while the write ID FIFO is empty");

  r_has_id: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_resp_i.r_valid |-> !rd_empty_i)
    else $error("R valid raised while the read ID FIFO is empty");

  b_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv_resp_i.b_valid && !slv_req_i.b_ready) |=>
      (slv_resp_i.b_valid && $stable(slv_resp_i.b)))
    else $error("B response changed before its handshake");

  r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv_resp_i.r_valid && !slv_req_i.r_ready) |=>
      (slv_resp_i.r_valid && $stable(slv_resp_i.r)))
    else $error("R beat changed before its handshake");

  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mst_req_i.aw_valid && !mst_resp_i.aw_ready) |=>
      (mst_req_i.aw_valid && $stable(mst_req_i.aw)))
    else $error("Downstream AW changed before its handshake");

  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mst_req_i.ar_valid && !mst_resp_i.ar_ready) |=>
      (mst_req_i.ar_valid && $stable(mst_req_i.ar)))
    else $error("Downstream AR changed before its handshake");

endmodule

bind axi_serializer axi_ser_assert i_axi_ser_assert (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .slv_req_i  (slv_req_i),
  .slv_resp_i (slv_resp_o),
  .mst_req_i  (mst_req_o),
  .mst_resp_i (mst_resp_i),
  .wr_empty_i (wr_empty),
  .rd_empty_i (rd_empty)
);

`default_nettype wire

// File: bench/axi_ser_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ser_tb;

  localparam int unsigned MaxReadTxns   = 2;
  localparam int unsigned MaxWriteTxns  = 2;
  localparam int unsigned MemWords      = 16;
  localparam int unsigned RdQueueDepth  = 4;
  localparam int unsigned IdxW          = $clog2(MemWords);
  localparam int unsigned TimeoutCycles = 400;

  logic           clk = 1'b0;
  logic           rst_n;
  axi_pkg::req_t  slv_req;
  axi_pkg::resp_t slv_resp;

  logic [15:0]      lfsr_state = 16'd83;
  axi_pkg::data_t   model_mem [MemWords];
  axi_pkg::b_chan_t b_exp_q [$];
  axi_pkg::r_chan_t r_exp_q [$];
  axi_pkg::b_chan_t b_exp;
  axi_pkg::r_chan_t r_exp;
  axi_pkg::b_chan_t b_prev;
  axi_pkg::r_chan_t r_prev;
  logic             b_held = 1'b0;
  logic             r_held = 1'b0;
  logic [31:0]      beat_addr;
  int unsigned      rd_outstanding = 0;
  int unsigned      value_errors = 0;
  int unsigned      proto_errors = 0;
  int unsigned      timeouts = 0;
  logic             rand_ready;
  logic             hold_r;

  axi_ser_top #(
    .MaxReadTxns  (MaxReadTxns),
    .MaxWriteTxns (MaxWriteTxns),
    .MemWords     (MemWords),
    .RdQueueDepth (RdQueueDepth)
  ) i_axi_ser_top (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp)
  );

  always #50 clk = ~clk;

  // Taps 16, 14, 13 and 11 with one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[14:0],
                    lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic responses_pending(input logic with_writes);
    return (r_exp_q.size() != 0) || (with_writes && (b_exp_q.size() != 0));
  endfunction

  task automatic end_run();
    $display("Errors: %0d value mismatches, %0d protocol errors, %0d timeouts",
             value_errors, proto_errors, timeouts);
    if (value_errors + proto_errors + timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  task automatic compare_b(input string name, input axi_pkg::b_chan_t exp_b,
                           input axi_pkg::b_chan_t act_b);
    if (act_b !== exp_b) begin
      value_errors++;
      $display("Fail %0t %s expected id=%h resp=%h actual id=%h resp=%h",
               $time, name, exp_b.id, exp_b.resp, act_b.id, act_b.resp);
    end
  endtask

  task automatic compare_r(input string name, input axi_pkg::r_chan_t exp_r,
                           input axi_pkg::r_chan_t act_r);
    if (act_r !== exp_r) begin
      value_errors++;
      $display("Fail %0t %s exp id=%h data=%h resp=%h last=%b act id=%h data=%h resp=%h last=%b",
               $time, name, exp_r.id, exp_r.data, exp_r.resp, exp_r.last,
               act_r.id, act_r.data, act_r.resp, act_r.last);
    end
  endtask

  // Inputs change 1 ns after the edge and the readies are redrawn every cycle
  task automatic next_cycle();
    @(posedge clk);
    #1;
    if (hold_r) begin
      slv_req.r_ready = 1'b0;
    end else if (rand_ready) begin
      slv_req.r_ready = 1'(rand_bits(1));
    end else begin
      slv_req.r_ready = 1'b1;
    end
    slv_req.b_ready = rand_ready ? 1'(rand_bits(1)) : 1'b1;
  endtask

  task automatic await_address(input logic is_read);
    int unsigned cycles;
    logic        ready;
    cycles = 0;
    @(negedge clk);
    ready = is_read ? slv_resp.ar_ready : slv_resp.aw_ready;
    while (!ready && cycles < TimeoutCycles) begin
      next_cycle();
      @(negedge clk);
      ready = is_read ? slv_resp.ar_ready : slv_resp.aw_ready;
      cycles++;
    end
    if (!ready) begin
      $display("Timeout: the %s address was never accepted", is_read ? "read" : "write");
      timeouts++;
    end
    next_cycle();
  endtask

  task automatic drain_responses(input logic with_writes);
    int unsigned cycles;
    cycles = 0;
    while (responses_pending(with_writes) && cycles < TimeoutCycles) begin
      next_cycle();
      cycles++;
    end
    if (responses_pending(with_writes)) begin
      $display("Timeout: expected responses never arrived");
      timeouts++;
    end
  endtask

  task automatic write_word(input axi_pkg::id_t id, input axi_pkg::addr_t addr,
                            input axi_pkg::data_t data);
    // Bursts still in flight would otherwise read the new word
    drain_responses(1'b0);
    slv_req.aw.id    = id;
    slv_req.aw.addr  = addr;
    slv_req.w.data   = data;
    slv_req.w.last   = 1'b1;
    slv_req.aw_valid = 1'b1;
    slv_req.w_valid  = 1'b1;
    await_address(1'b0);
    slv_req.aw_valid = 1'b0;
    slv_req.w_valid  = 1'b0;
  endtask

  task automatic read_burst(input axi_pkg::id_t id, input axi_pkg::addr_t addr,
                            input axi_pkg::len_t len);
    slv_req.ar.id    = id;
    slv_req.ar.addr  = addr;
    slv_req.ar.len   = len;
    slv_req.ar_valid = 1'b1;
    await_address(1'b1);
    slv_req.ar_valid = 1'b0;
  endtask

  // Transfers seen here complete on the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (b_held) begin
        compare_b("slv_resp_o.b (held)", b_prev, slv_resp.b);
      end
      if (r_held) begin
        compare_r("slv_resp_o.r (held)", r_prev, slv_resp.r);
      end
      b_held = slv_resp.b_valid && !slv_req.b_ready;
      r_held = slv_resp.r_valid && !slv_req.r_ready;
      b_prev = slv_resp.b;
      r_prev = slv_resp.r;
      if (slv_resp.b_valid && slv_req.b_ready) begin
        if (b_exp_q.size() == 0) begin
          $display("B response at %0t with no write outstanding", $time);
          proto_errors++;
        end else begin
          b_exp = b_exp_q.pop_front();
          compare_b("slv_resp_o.b", b_exp, slv_resp.b);
        end
      end
      if (slv_resp.r_valid && slv_req.r_ready) begin
        if (r_exp_q.size() == 0) begin
          $display("R beat at %0t with no read beat expected", $time);
          proto_errors++;
        end else begin
          r_exp = r_exp_q.pop_front();
          compare_r("slv_resp_o.r", r_exp, slv_resp.r);
          if (r_exp.last && rd_outstanding != 0) begin
            rd_outstanding--;
          end
        end
      end
      if (slv_req.aw_valid && slv_resp.aw_ready) begin
        // The write data goes in on the same edge as its address
        if (slv_resp.w_ready !== 1'b1) begin
          $display("Fail %0t slv_resp_o.w_ready expected 1 actual %b", $time, slv_resp.w_ready);
          value_errors++;
        end
        b_exp.id = slv_req.aw.id;
        if (32'(slv_req.aw.addr) < MemWords) begin
          b_exp.resp = mem_pkg::OKAY;
          model_mem[slv_req.aw.addr[IdxW-1:0]] = slv_req.w.data;
        end else begin
          b_exp.resp = mem_pkg::DECERR;
        end
        b_exp_q.push_back(b_exp);
      end
      if (slv_req.ar_valid && slv_resp.ar_ready) begin
        rd_outstanding++;
        for (int unsigned i = 0; i <= 32'(slv_req.ar.len); i++) begin
          beat_addr  = 32'(slv_req.ar.addr) + i;
          r_exp.id   = slv_req.ar.id;
          r_exp.last = (i == 32'(slv_req.ar.len));
          if (beat_addr < MemWords) begin
            r_exp.data = model_mem[beat_addr[IdxW-1:0]];
            r_exp.resp = mem_pkg::OKAY;
          end else begin
            r_exp.data = '0;
            r_exp.resp = mem_pkg::DECERR;
          end
          r_exp_q.push_back(r_exp);
        end
        if (rd_outstanding > MaxReadTxns) begin
          $display("More than %0d reads outstanding at %0t", MaxReadTxns, $time);
          proto_errors++;
        end
      end
    end
  end

  initial begin
    axi_pkg::id_t   rid;
    axi_pkg::addr_t raddr;
    axi_pkg::len_t  rlen;
    axi_pkg::data_t rdata;
    slv_req    = '0;
    rst_n      = 1'b0;
    rand_ready = 1'b0;
    hold_r     = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    // Fill every word so that later reads have a defined answer
    for (int unsigned a = 0; a < MemWords; a++) begin
      write_word(axi_pkg::id_t'(a), axi_pkg::addr_t'(a),
                 {8'h5A, 8'(a), 8'(~a), 8'(a) ^ 8'h3C});
    end
    write_word(4'h5, 8'd3, 32'hCAFE_0001);
    read_burst(4'h9, 8'd3, 2'd0);
    // Address 17 would alias onto word 1 if its range check failed
    write_word(4'h2, 8'd1, 32'h1111_2222);
    write_word(4'h3, 8'd17, 32'hDEAD_BEEF);
    read_burst(4'h4, 8'd1, 2'd0);
    read_burst(4'h6, 8'd14, 2'd3);
    read_burst(4'h7, 8'd17, 2'd1);
    drain_responses(1'b1);
    // Two held bursts fill the read ID FIFO and the third AR has to wait
    hold_r = 1'b1;
    next_cycle();
    read_burst(4'hA, 8'd0, 2'd3);
    read_burst(4'hB, 8'd4, 2'd2);
    slv_req.ar.id    = 4'hC;
    slv_req.ar.addr  = 8'd8;
    slv_req.ar.len   = 2'd1;
    slv_req.ar_valid = 1'b1;
    repeat (10) begin
      @(negedge clk);
      if (slv_resp.ar_ready) begin
        $display("Read address accepted at %0t beyond the outstanding limit", $time);
        proto_errors++;
      end
      next_cycle();
    end
    hold_r = 1'b0;
    await_address(1'b1);
    slv_req.ar_valid = 1'b0;
    drain_responses(1'b1);
    rand_ready = 1'b1;
    repeat (80) begin
      rid   = axi_pkg::id_t'(rand_bits(4));
      raddr = axi_pkg::addr_t'(rand_bits(5) % 20);
      if (rand_bits(1) == 32'd1) begin
        rdata = rand_bits(32);
        write_word(rid, raddr, rdata);
      end else begin
        rlen = axi_pkg::len_t'(rand_bits(2));
        read_burst(rid, raddr, rlen);
      end
    end
    drain_responses(1'b1);
    repeat (4) next_cycle();
    end_run();
  end

endmodule

`default_nettype wire

// File: design/axi_mem_sub.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_sub #(
  parameter int unsigned MemWords     = 16,
  parameter int unsigned RdQueueDepth = 4
) (
  input  wire logic          clk_i,
  input  wire logic          rst_n_i,
  input  wire axi_pkg::req_t  req_i,
  output axi_pkg::resp_t     resp_o
);

  localparam int unsigned IdxW = (MemWords > 1) ? $clog2(MemWords) : 1;

  axi_pkg::data_t     mem_q [MemWords];

  mem_pkg::wr_state_e wr_state_q;
  axi_pkg::id_t       b_id_q;
  mem_pkg::resp_e     b_resp_q;
  logic               wr_fire;
  logic               wr_in_range;

  mem_pkg::rd_state_e rd_state_q;
  axi_pkg::ar_chan_t  rd_ar_q;
  axi_pkg::len_t      rd_beat_q;
  axi_pkg::ar_chan_t  q_head;
  logic               q_full;
  logic               q_empty;
  logic               q_pop;
  logic               rd_in_range;
  logic               rd_last;

  // AW and W are taken on the same edge and only while no B is pending
  assign wr_fire     = req_i.aw_valid & req_i.w_valid & (wr_state_q == mem_pkg::WR_IDLE);
  assign wr_in_range = (32'(req_i.aw.addr) < MemWords);

  always_ff @(posedge clk_i) begin
    if (wr_fire && wr_in_range) begin
      mem_q[req_i.aw.addr[IdxW-1:0]] <= req_i.w.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_id_q   <= req_i.aw.id;
      b_resp_q <= wr_in_range ? mem_pkg::OKAY : mem_pkg::DECERR;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_state_q <= mem_pkg::WR_IDLE;
    end else begin
      case (wr_state_q)
        mem_pkg::WR_IDLE: if (wr_fire) wr_state_q <= mem_pkg::WR_RESP;
        mem_pkg::WR_RESP: if (req_i.b_ready) wr_state_q <= mem_pkg::WR_IDLE;
        default:          wr_state_q <= mem_pkg::WR_IDLE;
      endcase
    end
  end

  // Read requests wait here until the burst in flight has finished
  id_fifo #(
    .Depth (RdQueueDepth),
    .T     (axi_pkg::ar_chan_t)
  ) i_rd_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (req_i.ar_valid),
    .data_i  (req_i.ar),
    .pop_i   (q_pop),
    .full_o  (q_full),
    .empty_o (q_empty),
    .data_o  (q_head)
  );

  assign q_pop       = (rd_state_q == mem_pkg::RD_IDLE) & ~q_empty;
  assign rd_last     = (rd_beat_q == rd_ar_q.len);
  assign rd_in_range = (32'(rd_ar_q.addr) < MemWords);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_state_q <= mem_pkg::RD_IDLE;
    end else begin
      case (rd_state_q)
        mem_pkg::RD_IDLE:  if (!q_empty) rd_state_q <= mem_pkg::RD_BURST;
        mem_pkg::RD_BURST: if (req_i.r_ready && rd_last) rd_state_q <= mem_pkg::RD_IDLE;
        default:           rd_state_q <= mem_pkg::RD_IDLE;
      endcase
    end
  end

  // Current burst address advances once per accepted beat
  always_ff @(posedge clk_i) begin
    if (q_pop) begin
      rd_ar_q   <= q_head;
      rd_beat_q <= '0;
    end else if (rd_state_q == mem_pkg::RD_BURST && req_i.r_ready && !rd_last) begin
      rd_ar_q.addr <= rd_ar_q.addr + 1'b1;
      rd_beat_q    <= rd_beat_q + 1'b1;
    end
  end

  always_comb begin
    resp_o.aw_ready = (wr_state_q == mem_pkg::WR_IDLE) & req_i.w_valid;
    resp_o.w_ready  = (wr_state_q == mem_pkg::WR_IDLE) & req_i.aw_valid;
    resp_o.b.id     = b_id_q;
    resp_o.b.resp   = b_resp_q;
    resp_o.b_valid  = (wr_state_q == mem_pkg::WR_RESP);

    resp_o.ar_ready = ~q_full;
    resp_o.r.id     = rd_ar_q.id;
    // Each beat is range checked on its own address
    resp_o.r.data   = rd_in_range ? mem_q[rd_ar_q.addr[IdxW-1:0]] : '0;
    resp_o.r.resp   = rd_in_range ? mem_pkg::OKAY : mem_pkg::DECERR;
    resp_o.r.last   = rd_last;
    resp_o.r_valid  = (rd_state_q == mem_pkg::RD_BURST);
  end

endmodule

`default_nettype wire

// File: design/axi_pkg.sv
`default_nettype none

package axi_pkg;

  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 8;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned LenWidth  = 2;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  // Beat count of a read burst is len plus one
  typedef logic [LenWidth-1:0]  len_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t            id;
    mem_pkg::resp_e resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  typedef struct packed {
    id_t            id;
    data_t          data;
    mem_pkg::resp_e resp;
    logic           last;
  } r_chan_t;

  // Manager to subordinate direction
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } req_t;

  // Subordinate to manager direction
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } resp_t;

endpackage

`default_nettype wire

// File: design/axi_ser_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ser_top #(
  parameter int unsigned MaxReadTxns  = 2,
  parameter int unsigned MaxWriteTxns = 2,
  parameter int unsigned MemWords     = 16,
  parameter int unsigned RdQueueDepth = 4
) (
  input  wire logic          clk_i,
  input  wire logic          rst_n_i,
  input  wire axi_pkg::req_t  slv_req_i,
  output axi_pkg::resp_t     slv_resp_o
);

  // Serialized bus between the ID tracker and the memory
  axi_pkg::req_t  mst_req;
  axi_pkg::resp_t mst_resp;

  axi_serializer #(
    .MaxReadTxns  (MaxReadTxns),
    .MaxWriteTxns (MaxWriteTxns)
  ) i_axi_serializer (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .slv_req_i  (slv_req_i),
    .slv_resp_o (slv_resp_o),
    .mst_req_o  (mst_req),
    .mst_resp_i (mst_resp)
  );

  axi_mem_sub #(
    .MemWords     (MemWords),
    .RdQueueDepth (RdQueueDepth)
  ) i_axi_mem_sub (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (mst_req),
    .resp_o  (mst_resp)
  );

endmodule

`default_nettype wire

// File: design/axi_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module axi_serializer #(
  parameter int unsigned MaxReadTxns  = 2,
  parameter int unsigned MaxWriteTxns = 2
) (
  input  wire logic          clk_i,
  input  wire logic          rst_n_i,
  input  wire axi_pkg::req_t  slv_req_i,
  output axi_pkg::resp_t     slv_resp_o,
  output axi_pkg::req_t      mst_req_o,
  input  wire axi_pkg::resp_t mst_resp_i
);

  logic          wr_full;
  logic          wr_empty;
  logic          rd_full;
  logic          rd_empty;
  axi_pkg::id_t  b_id;
  axi_pkg::id_t  r_id;

  always_comb begin
    mst_req_o  = slv_req_i;
    slv_resp_o = mst_resp_i;

    // Every downstream transaction runs on ID zero
    mst_req_o.aw.id = '0;
    mst_req_o.ar.id = '0;

    // Responses come back in order, so the FIFO head holds their ID
    slv_resp_o.b.id = b_id;
    slv_resp_o.r.id = r_id;

    // No new address is taken while its ID FIFO is full
    mst_req_o.aw_valid  = slv_req_i.aw_valid & ~wr_full;
    slv_resp_o.aw_ready = mst_resp_i.aw_ready & ~wr_full;
    mst_req_o.ar_valid  = slv_req_i.ar_valid & ~rd_full;
    slv_resp_o.ar_ready = mst_resp_i.ar_ready & ~rd_full;

    // A response without a recorded ID is held back
    slv_resp_o.b_valid = mst_resp_i.b_valid & ~wr_empty;
    mst_req_o.b_ready  = slv_req_i.b_ready & ~wr_empty;
    slv_resp_o.r_valid = mst_resp_i.r_valid & ~rd_empty;
    mst_req_o.r_ready  = slv_req_i.r_ready & ~rd_empty;
  end

  id_fifo #(
    .Depth (MaxWriteTxns),
    .T     (axi_pkg::id_t)
  ) i_wr_id_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (slv_req_i.aw_valid & slv_resp_o.aw_ready),
    .data_i  (slv_req_i.aw.id),
    .pop_i   (slv_resp_o.b_valid & slv_req_i.b_ready),
    .full_o  (wr_full),
    .empty_o (wr_empty),
    .data_o  (b_id)
  );

  // A read ID stays queued until the final beat of its burst
  id_fifo #(
    .Depth (MaxReadTxns),
    .T     (axi_pkg::id_t)
  ) i_rd_id_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (slv_req_i.ar_valid & slv_resp_o.ar_ready),
    .data_i  (slv_req_i.ar.id),
    .pop_i   (slv_resp_o.r_valid & slv_req_i.r_ready & slv_resp_o.r.last),
    .full_o  (rd_full),
    .empty_o (rd_empty),
    .data_o  (r_id)
  );

endmodule

`default_nettype wire

// File: design/id_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module id_fifo #(
  parameter int unsigned Depth = 2,
  parameter type         T     = logic
) (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  wire logic push_i,
  input  wire T     data_i,
  input  wire logic pop_i,
  output logic      full_o,
  output logic      empty_o,
  output T          data_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  T              mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            do_push;
  logic            do_pop;

  assign full_o  = (cnt_q == CntW'(Depth));
  assign empty_o = (cnt_q == '0);

  // Head entry falls through to the output as soon as it is stored
  assign data_o = mem_q[rd_ptr_q];

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the occupancy as it is
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // Response codes carried on B and R with the encoding of a full AXI bus
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } resp_e;

  typedef enum logic {
    RD_IDLE,
    RD_BURST
  } rd_state_e;

  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } wr_state_e;

endpackage

`default_nettype wire

// File: filelist.f
design/mem_pkg.sv
design/axi_pkg.sv
design/id_fifo.sv
design/axi_serializer.sv
design/axi_mem_sub.sv
design/axi_ser_top.sv
bench/axi_ser_assert.sv
bench/axi_ser_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module axi_ser_tb -f filelist.f -o sim_axi_ser
./obj_dir/sim_axi_ser | tee sim.log

if grep -q "TB FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failure"
